/* hw/alu.sv */
`timescale 1ns/100ps

module alu (
  input  isa_pkg::opcode_t  opcode_i,
  input  isa_pkg::funct_t   funct_i,
  input  isa_pkg::word_t    rs_i,
  input  isa_pkg::word_t    rt_i,
  input  isa_pkg::word_t    pc_i,
  input  isa_pkg::shamt_t   shamt_i,
  input  isa_pkg::imm_t     imm_i,
  input  isa_pkg::jtarget_t target_i,
  input  logic              imm_b_i,
  output isa_pkg::word_t    result_o,
  output isa_pkg::word_t    eff_addr_o,
  output isa_pkg::word_t    branch_target_o,
  output logic              taken_o
);

  isa_pkg::word_t imm_sext;
  isa_pkg::word_t imm_ext;
  isa_pkg::word_t op_b;
  isa_pkg::word_t pc_plus4;

  assign imm_sext = {{16{imm_i[15]}}, imm_i};
  assign pc_plus4 = pc_i + 32'd4;

  // ORI zero-extends and LUI moves the immediate to the upper half
  always_comb begin
    case (opcode_i)
      isa_pkg::OP_ORI: imm_ext = {16'h0000, imm_i};
      isa_pkg::OP_LUI: imm_ext = {imm_i, 16'h0000};
      default:         imm_ext = imm_sext;
    endcase
  end

  assign op_b = imm_b_i ? imm_ext : rt_i;

  always_comb begin
    result_o = '0;
    case (opcode_i)
      isa_pkg::OP_SPECIAL: begin
        case (funct_i)
          isa_pkg::FN_ADDU: result_o = rs_i + op_b;
          isa_pkg::FN_SUBU: result_o = rs_i - op_b;
          isa_pkg::FN_AND:  result_o = rs_i & op_b;
          isa_pkg::FN_OR:   result_o = rs_i | op_b;
          isa_pkg::FN_XOR:  result_o = rs_i ^ op_b;
          isa_pkg::FN_SLT:  result_o = {31'd0, $signed(rs_i) < $signed(op_b)};
          isa_pkg::FN_SLL:  result_o = rt_i << shamt_i;
          isa_pkg::FN_SRL:  result_o = rt_i >> shamt_i;
          default:          result_o = '0;
        endcase
      end
      isa_pkg::OP_ADDIU: result_o = rs_i + op_b;
      isa_pkg::OP_ORI:   result_o = rs_i | op_b;
      isa_pkg::OP_LUI:   result_o = op_b;
      // Return address skips the delay slot
      isa_pkg::OP_JAL:   result_o = pc_i + 32'd8;
      default:           result_o = '0;
    endcase
  end

  assign eff_addr_o = rs_i + imm_sext;

  always_comb begin
    case (opcode_i)
      isa_pkg::OP_BEQ, isa_pkg::OP_BNE: branch_target_o = pc_plus4 + {imm_sext[29:0], 2'b00};
      isa_pkg::OP_J, isa_pkg::OP_JAL:   branch_target_o = {pc_plus4[31:28], target_i, 2'b00};
      isa_pkg::OP_SPECIAL:              branch_target_o = rs_i;
      default:                          branch_target_o = pc_plus4;
    endcase
  end

  always_comb begin
    case (opcode_i)
      isa_pkg::OP_J, isa_pkg::OP_JAL: taken_o = 1'b1;
      isa_pkg::OP_BEQ:                taken_o = (rs_i == rt_i);
      isa_pkg::OP_BNE:                taken_o = (rs_i != rt_i);
      isa_pkg::OP_SPECIAL:            taken_o = (funct_i == isa_pkg::FN_JR);
      default:                        taken_o = 1'b0;
    endcase
  end

endmodule

/* hw/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// First instruction fetched after reset
`define CPU_RESET_VECTOR 32'hBFC0_0000

// Reaching this address ends execution
`define CPU_HALT_ADDR 32'h0000_0000

// Register indices with a fixed role
`define CPU_REG_V0 5'd2
`define CPU_REG_RA 5'd31

`endif

/* hw/cpu_control.sv */
`timescale 1ns/100ps

module cpu_control (
  input  cpu_pkg::state_t  state_i,
  input  isa_pkg::opcode_t opcode_i,
  input  isa_pkg::funct_t  funct_i,
  input  logic             waitrequest_i,
  output cpu_pkg::ctrl_t   ctrl_o,
  output logic             read_o,
  output logic             write_o,
  output logic             mem_op_o
);

  assign mem_op_o = (opcode_i == isa_pkg::OP_LW) || (opcode_i == isa_pkg::OP_SW);

  always_comb begin
    ctrl_o = '0;
    ctrl_o.wb_sel = cpu_pkg::WB_RD;
    read_o = 1'b0;
    write_o = 1'b0;
    case (state_i)
      cpu_pkg::FETCH: begin
        read_o = 1'b1;
        // Capture only in the completion cycle
        ctrl_o.ir_we = !waitrequest_i;
      end
      cpu_pkg::EXEC: begin
        ctrl_o.pc_we = 1'b1;
        case (opcode_i)
          isa_pkg::OP_SPECIAL: begin
            ctrl_o.rf_we = (funct_i != isa_pkg::FN_JR);
            ctrl_o.wb_sel = cpu_pkg::WB_RD;
          end
          isa_pkg::OP_ADDIU, isa_pkg::OP_ORI, isa_pkg::OP_LUI: begin
            ctrl_o.rf_we = 1'b1;
            ctrl_o.wb_sel = cpu_pkg::WB_RT;
            ctrl_o.imm_b = 1'b1;
          end
          isa_pkg::OP_JAL: begin
            // Link value comes from the ALU
            ctrl_o.rf_we = 1'b1;
            ctrl_o.wb_sel = cpu_pkg::WB_GPR31;
          end
          default: begin
            ctrl_o.rf_we = 1'b0;
          end
        endcase
      end
      cpu_pkg::MEM: begin
        ctrl_o.addr_sel = 1'b1;
        if (opcode_i == isa_pkg::OP_LW) begin
          read_o = 1'b1;
          ctrl_o.load_sel = 1'b1;
          ctrl_o.wb_sel = cpu_pkg::WB_RT;
          ctrl_o.rf_we = !waitrequest_i;
        end else begin
          write_o = 1'b1;
        end
      end
      default: begin
        read_o = 1'b0;
      end
    endcase
  end

endmodule

/* hw/cpu_fsm.sv */
`timescale 1ns/100ps

module cpu_fsm (
  input  logic            clk,
  input  logic            rst_i,
  input  logic            stall_i,
  input  logic            halt_i,
  input  logic            mem_op_i,
  output cpu_pkg::state_t state_o
);

  cpu_pkg::state_t state_q;
  cpu_pkg::state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      cpu_pkg::FETCH: begin
        // Halt wins over a pending fetch
        if (halt_i) begin
          state_d = cpu_pkg::HALT;
        end else if (!stall_i) begin
          state_d = cpu_pkg::EXEC;
        end
      end
      cpu_pkg::EXEC: begin
        state_d = mem_op_i ? cpu_pkg::MEM : cpu_pkg::FETCH;
      end
      cpu_pkg::MEM: begin
        if (!stall_i) begin
          state_d = cpu_pkg::FETCH;
        end
      end
      default: begin
        state_d = cpu_pkg::HALT;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= cpu_pkg::FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

/* hw/cpu_pkg.sv */
package cpu_pkg;

  typedef enum logic [1:0] {
    FETCH,
    EXEC,
    MEM,
    HALT
  } state_t;

  // Destination register of a write-back
  typedef enum logic [1:0] {
    WB_RD,
    WB_RT,
    WB_GPR31
  } wb_sel_t;

  typedef struct packed {
    logic    ir_we;
    logic    pc_we;
    logic    rf_we;
    wb_sel_t wb_sel;
    logic    load_sel;
    logic    addr_sel;
    logic    imm_b;
  } ctrl_t;

  // Everything the Avalon master drives
  typedef struct packed {
    isa_pkg::word_t address;
    logic           read;
    logic           write;
    isa_pkg::word_t writedata;
    logic [3:0]     byteenable;
  } bus_req_t;

endpackage

/* hw/instr_reg.sv */
`timescale 1ns/100ps

module instr_reg (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              we_i,
  input  isa_pkg::word_t    instr_i,
  output isa_pkg::opcode_t  opcode_o,
  output isa_pkg::funct_t   funct_o,
  output isa_pkg::regaddr_t rs_o,
  output isa_pkg::regaddr_t rt_o,
  output isa_pkg::regaddr_t rd_o,
  output isa_pkg::shamt_t   shamt_o,
  output isa_pkg::imm_t     imm_o,
  output isa_pkg::jtarget_t target_o
);

  isa_pkg::word_t ir_q;

  // Cleared to a NOP (SLL $0, $0, 0)
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ir_q <= '0;
    end else if (we_i) begin
      ir_q <= instr_i;
    end
  end

  assign opcode_o = isa_pkg::opcode_t'(ir_q[31:26]);
  assign funct_o = isa_pkg::funct_t'(ir_q[5:0]);
  assign rs_o = ir_q[25:21];
  assign rt_o = ir_q[20:16];
  assign rd_o = ir_q[15:11];
  assign shamt_o = ir_q[10:6];
  assign imm_o = ir_q[15:0];
  assign target_o = ir_q[25:0];

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] regaddr_t;
  typedef logic [4:0] shamt_t;
  typedef logic [15:0] imm_t;
  typedef logic [25:0] jtarget_t;

  // Primary opcode field, bits 31:26
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ORI     = 6'h0D,
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_t;

  // Function field of SPECIAL instructions, bits 5:0
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2A
  } funct_t;

endpackage

/* hw/mips_cpu_bus.sv */
`timescale 1ns/100ps

`include "cpu_consts.svh"

module mips_cpu_bus (
  input  logic           clk,
  input  logic           rst_i,
  input  logic           waitrequest_i,
  input  isa_pkg::word_t readdata_i,
  output logic           active_o,
  output isa_pkg::word_t register_v0_o,
  output isa_pkg::word_t address_o,
  output isa_pkg::word_t writedata_o,
  output logic           read_o,
  output logic           write_o,
  output logic [3:0]     byteenable_o
);

  // Bus lanes are little-endian and the CPU is big-endian
  function automatic isa_pkg::word_t swap_bytes(isa_pkg::word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  cpu_pkg::state_t   state;
  cpu_pkg::ctrl_t    ctrl;
  cpu_pkg::bus_req_t bus;
  logic              ctl_read;
  logic              ctl_write;
  logic              mem_op;
  logic              halt;
  logic              stall;
  logic              taken;
  isa_pkg::word_t    pc;
  isa_pkg::word_t    rdata_be;
  isa_pkg::word_t    rs_data;
  isa_pkg::word_t    rt_data;
  isa_pkg::word_t    wb_data;
  isa_pkg::word_t    alu_result;
  isa_pkg::word_t    eff_addr;
  isa_pkg::word_t    br_target;
  isa_pkg::regaddr_t wb_addr;
  isa_pkg::opcode_t  opcode;
  isa_pkg::funct_t   funct;
  isa_pkg::regaddr_t rs;
  isa_pkg::regaddr_t rt;
  isa_pkg::regaddr_t rd;
  isa_pkg::shamt_t   shamt;
  isa_pkg::imm_t     imm;
  isa_pkg::jtarget_t jtarget;

  assign rdata_be = swap_bytes(readdata_i);
  assign halt = (pc == `CPU_HALT_ADDR);
  assign stall = (bus.read || bus.write) && waitrequest_i;

  cpu_fsm u_fsm (
    .clk      (clk),
    .rst_i    (rst_i),
    .stall_i  (stall),
    .halt_i   (halt),
    .mem_op_i (mem_op),
    .state_o  (state)
  );

  cpu_control u_control (
    .state_i       (state),
    .opcode_i      (opcode),
    .funct_i       (funct),
    .waitrequest_i (waitrequest_i),
    .ctrl_o        (ctrl),
    .read_o        (ctl_read),
    .write_o       (ctl_write),
    .mem_op_o      (mem_op)
  );

  pc_unit u_pc (
    .clk      (clk),
    .rst_i    (rst_i),
    .we_i     (ctrl.pc_we),
    .taken_i  (taken),
    .target_i (br_target),
    .pc_o     (pc)
  );

  instr_reg u_ir (
    .clk      (clk),
    .rst_i    (rst_i),
    .we_i     (ctrl.ir_we),
    .instr_i  (rdata_be),
    .opcode_o (opcode),
    .funct_o  (funct),
    .rs_o     (rs),
    .rt_o     (rt),
    .rd_o     (rd),
    .shamt_o  (shamt),
    .imm_o    (imm),
    .target_o (jtarget)
  );

  always_comb begin
    case (ctrl.wb_sel)
      cpu_pkg::WB_RT:    wb_addr = rt;
      cpu_pkg::WB_GPR31: wb_addr = `CPU_REG_RA;
      default:           wb_addr = rd;
    endcase
  end

  assign wb_data = ctrl.load_sel ? rdata_be : alu_result;

  reg_file u_regs (
    .clk      (clk),
    .rst_i    (rst_i),
    .we_i     (ctrl.rf_we),
    .raddr1_i (rs),
    .raddr2_i (rt),
    .waddr_i  (wb_addr),
    .wdata_i  (wb_data),
    .rdata1_o (rs_data),
    .rdata2_o (rt_data),
    .v0_o     (register_v0_o)
  );

  alu u_alu (
    .opcode_i        (opcode),
    .funct_i         (funct),
    .rs_i            (rs_data),
    .rt_i            (rt_data),
    .pc_i            (pc),
    .shamt_i         (shamt),
    .imm_i           (imm),
    .target_i        (jtarget),
    .imm_b_i         (ctrl.imm_b),
    .result_o        (alu_result),
    .eff_addr_o      (eff_addr),
    .branch_target_o (br_target),
    .taken_o         (taken)
  );

  // No fetch goes out from the halt address
  always_comb begin
    bus.read = ctl_read && !(halt && (state == cpu_pkg::FETCH));
    bus.write = ctl_write;
    bus.address = ctrl.addr_sel ? eff_addr : pc;
    bus.writedata = swap_bytes(rt_data);
    bus.byteenable = (bus.read || bus.write) ? 4'hF : 4'h0;
  end

  assign address_o = bus.address;
  assign read_o = bus.read;
  assign write_o = bus.write;
  assign writedata_o = bus.writedata;
  assign byteenable_o = bus.byteenable;
  assign active_o = (state != cpu_pkg::HALT);

endmodule

/* hw/pc_unit.sv */
`timescale 1ns/100ps

`include "cpu_consts.svh"

module pc_unit (
  input  logic           clk,
  input  logic           rst_i,
  input  logic           we_i,
  input  logic           taken_i,
  input  isa_pkg::word_t target_i,
  output isa_pkg::word_t pc_o
);

  isa_pkg::word_t pc_q;
  isa_pkg::word_t pend_target_q;
  logic           pend_valid_q;

  // Target of a taken branch waits one instruction for the delay slot
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= `CPU_RESET_VECTOR;
      pend_valid_q <= 1'b0;
    end else if (we_i) begin
      pc_q <= pend_valid_q ? pend_target_q : pc_q + 32'd4;
      pend_valid_q <= taken_i;
    end
  end

  always_ff @(posedge clk) begin
    if (we_i && taken_i) begin
      pend_target_q <= target_i;
    end
  end

  assign pc_o = pc_q;

endmodule

/* hw/reg_file.sv */
`timescale 1ns/100ps

`include "cpu_consts.svh"

module reg_file (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              we_i,
  input  isa_pkg::regaddr_t raddr1_i,
  input  isa_pkg::regaddr_t raddr2_i,
  input  isa_pkg::regaddr_t waddr_i,
  input  isa_pkg::word_t    wdata_i,
  output isa_pkg::word_t    rdata1_o,
  output isa_pkg::word_t    rdata2_o,
  output isa_pkg::word_t    v0_o
);

  isa_pkg::word_t regs_q [32];

  // All registers start at zero, and $zero never changes
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];
  assign v0_o = regs_q[`CPU_REG_V0];

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sources.f --top-module tb_mips_cpu --Mdir obj_dir -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "run.sh: testbench reported a failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "run.sh: simulator exited with status $status"
  exit 1
fi
echo "run.sh: simulation finished"

/* sources.f */
+incdir+hw
hw/isa_pkg.sv
hw/cpu_pkg.sv
hw/cpu_fsm.sv
hw/cpu_control.sv
hw/pc_unit.sv
hw/instr_reg.sv
hw/reg_file.sv
hw/alu.sv
hw/mips_cpu_bus.sv
tests/mips_cpu_sva.sv
tests/tb_mips_cpu.sv

/* tests/mips_cpu_sva.sv */
`timescale 1ns/100ps

module mips_cpu_sva (
  input logic           clk,
  input logic           rst_i,
  input logic           waitrequest_i,
  input logic           active_o,
  input isa_pkg::word_t address_o,
  input isa_pkg::word_t writedata_o,
  input logic           read_o,
  input logic           write_o,
  input logic [3:0]     byteenable_o
);

  int fail_count = 0;

  cpu_pkg::bus_req_t req;

  assign req = {address_o, read_o, write_o, writedata_o, byteenable_o};

  no_read_write_overlap: assert property (
    @(posedge clk) disable iff (rst_i) !(read_o && write_o))
  else begin
    fail_count++;
    $error("read_o and write_o are high together");
  end

  // Master holds the whole request during a stall
  request_stable: assert property (
    @(posedge clk) disable iff (rst_i) (read_o || write_o) && waitrequest_i |=> $stable(req))
  else begin
    fail_count++;
    $error("bus request changed while waitrequest_i was high");
  end

  halt_sticky: assert property (
    @(posedge clk) disable iff (rst_i) !active_o |=> !active_o)
  else begin
    fail_count++;
    $error("active_o rose again without a reset");
  end

endmodule

bind mips_cpu_bus mips_cpu_sva u_sva (
  .clk           (clk),
  .rst_i         (rst_i),
  .waitrequest_i (waitrequest_i),
  .active_o      (active_o),
  .address_o     (address_o),
  .writedata_o   (writedata_o),
  .read_o        (read_o),
  .write_o       (write_o),
  .byteenable_o  (byteenable_o)
);

/* tests/tb_mips_cpu.sv */
`timescale 1ns/100ps

`include "cpu_consts.svh"

module tb_mips_cpu;

  localparam int CLK_HALF = 4;
  // Each pass runs every program once, first with zero wait and then with random wait
  localparam int PROGS_PER_PASS = 17;
  localparam int NUM_RUNS = 2 * PROGS_PER_PASS;

  logic           clk;
  logic           rst_i;
  logic           waitrequest_i;
  isa_pkg::word_t readdata_i;
  logic           active_o;
  isa_pkg::word_t register_v0_o;
  isa_pkg::word_t address_o;
  isa_pkg::word_t writedata_o;
  logic           read_o;
  logic           write_o;
  logic [3:0]     byteenable_o;

  // Memory holds words exactly as they appear on the bus lanes
  isa_pkg::word_t prog_mem [64];
  isa_pkg::word_t data_mem [16];
  isa_pkg::word_t prog [$];

  isa_pkg::word_t op_seed = 32'd80499;
  isa_pkg::word_t wait_seed = 32'd80499;
  logic           random_wait;

  isa_pkg::word_t exp_v0;
  logic           exp_store;
  isa_pkg::word_t exp_store_val;
  logic           store_seen;
  isa_pkg::word_t store_addr;
  isa_pkg::word_t store_data;
  logic [3:0]     store_be;
  int             checks_done = 0;

  mips_cpu_bus u_dut (
    .clk           (clk),
    .rst_i         (rst_i),
    .waitrequest_i (waitrequest_i),
    .readdata_i    (readdata_i),
    .active_o      (active_o),
    .register_v0_o (register_v0_o),
    .address_o     (address_o),
    .writedata_o   (writedata_o),
    .read_o        (read_o),
    .write_o       (write_o),
    .byteenable_o  (byteenable_o)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  function automatic isa_pkg::word_t lcg_step(input isa_pkg::word_t s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic isa_pkg::word_t next_operand();
    op_seed = lcg_step(op_seed);
    return op_seed;
  endfunction

  function automatic isa_pkg::word_t byte_swap(input isa_pkg::word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic isa_pkg::word_t r_format(input isa_pkg::regaddr_t rs,
      input isa_pkg::regaddr_t rt, input isa_pkg::regaddr_t rd,
      input isa_pkg::shamt_t sh, input isa_pkg::funct_t fn);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic isa_pkg::word_t i_format(input isa_pkg::opcode_t op,
      input isa_pkg::regaddr_t rs, input isa_pkg::regaddr_t rt, input isa_pkg::imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic isa_pkg::word_t j_format(input isa_pkg::opcode_t op,
      input isa_pkg::jtarget_t t);
    return {op, t};
  endfunction

  // Expected register result of one ALU or immediate instruction
  function automatic isa_pkg::word_t ref_result(input isa_pkg::opcode_t op,
      input isa_pkg::funct_t fn, input isa_pkg::word_t a, input isa_pkg::word_t b,
      input isa_pkg::shamt_t sh, input isa_pkg::imm_t imm);
    case (op)
      isa_pkg::OP_SPECIAL: begin
        case (fn)
          isa_pkg::FN_ADDU: return a + b;
          isa_pkg::FN_SUBU: return a - b;
          isa_pkg::FN_AND:  return a & b;
          isa_pkg::FN_OR:   return a | b;
          isa_pkg::FN_XOR:  return a ^ b;
          isa_pkg::FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          isa_pkg::FN_SLL:  return b << sh;
          isa_pkg::FN_SRL:  return b >> sh;
          default:          return 32'd0;
        endcase
      end
      isa_pkg::OP_ADDIU: return a + {{16{imm[15]}}, imm};
      isa_pkg::OP_ORI:   return a | {16'h0000, imm};
      isa_pkg::OP_LUI:   return {imm, 16'h0000};
      default:           return 32'd0;
    endcase
  endfunction

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input isa_pkg::word_t got,
      input isa_pkg::word_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic read_memory(input isa_pkg::word_t addr, output isa_pkg::word_t data);
    isa_pkg::word_t prog_off;
    isa_pkg::word_t data_off;
    prog_off = addr - `CPU_RESET_VECTOR;
    data_off = addr - 32'h0000_1000;
    data = 32'd0;
    if (prog_off < 32'd256) begin
      data = prog_mem[prog_off[7:2]];
    end else if (data_off < 32'd64) begin
      data = data_mem[data_off[5:2]];
    end else begin
      stop_with_failure($sformatf("The CPU read from unmapped address 0x%08h", addr));
    end
  endtask

  // Slave side drives wait and read data 1 ns after the edge
  always @(posedge clk) begin
    #1;
    if (random_wait) begin
      wait_seed = lcg_step(wait_seed);
      waitrequest_i = wait_seed[16];
    end else begin
      waitrequest_i = 1'b0;
    end
    if (read_o === 1'b1) begin
      read_memory(address_o, readdata_i);
    end else begin
      readdata_i = 32'd0;
    end
  end

  // A write completes at the next rising edge
  always @(negedge clk) begin
    if (write_o === 1'b1 && waitrequest_i == 1'b0) begin
      store_seen = 1'b1;
      store_addr = address_o;
      store_data = writedata_o;
      store_be = byteenable_o;
      if (address_o - 32'h0000_1000 < 32'd64) begin
        data_mem[address_o[5:2]] = writedata_o;
      end else begin
        stop_with_failure($sformatf("The CPU wrote to unmapped address 0x%08h", address_o));
      end
    end
  end

  always @(negedge active_o) begin
    if (!rst_i) begin
      @(negedge clk);
      check_word("register_v0_o", register_v0_o, exp_v0);
      if (exp_store) begin
        if (store_seen !== 1'b1) begin
          stop_with_failure("The CPU finished without writing the stored word to memory");
        end
        check_word("address_o", store_addr, 32'h0000_1000);
        check_word("writedata_o", store_data, byte_swap(exp_store_val));
        check_word("byteenable_o", {28'h0, store_be}, 32'h0000_000F);
      end
      if (u_dut.u_sva.fail_count != 0) begin
        stop_with_failure("A bus protocol or halt assertion failed");
      end
      checks_done++;
    end
  end

  initial begin
    repeat (NUM_RUNS * 2000) @(posedge clk);
    stop_with_failure("Timeout: the CPU did not halt within the cycle budget");
  end

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_i = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst_i = 1'b0;
    @(negedge clk);
    check_bit("active_o", active_o, 1'b1);
    check_bit("read_o", read_o, 1'b1);
    check_bit("write_o", write_o, 1'b0);
    check_word("address_o", address_o, `CPU_RESET_VECTOR);
  endtask

  task automatic load_const(input isa_pkg::regaddr_t r, input isa_pkg::word_t v);
    prog.push_back(i_format(isa_pkg::OP_LUI, 5'd0, r, v[31:16]));
    prog.push_back(i_format(isa_pkg::OP_ORI, r, r, v[15:0]));
  endtask

  // JR $zero and its delay slot
  task automatic append_halt();
    prog.push_back(r_format(5'd0, 5'd0, 5'd0, 5'd0, isa_pkg::FN_JR));
    prog.push_back(32'h0000_0000);
  endtask

  task automatic run_program(input isa_pkg::word_t expected, input logic store,
      input isa_pkg::word_t store_val);
    int target;
    for (int i = 0; i < 64; i++) begin
      prog_mem[i] = (i < prog.size()) ? byte_swap(prog[i]) : 32'h0000_0000;
    end
    exp_v0 = expected;
    exp_store = store;
    exp_store_val = store_val;
    store_seen = 1'b0;
    target = checks_done + 1;
    apply_reset();
    wait (checks_done == target);
    prog.delete();
  endtask

  task automatic rtype_programs();
    isa_pkg::funct_t ops [8];
    isa_pkg::word_t  a;
    isa_pkg::word_t  b;
    isa_pkg::shamt_t sh;
    ops = '{isa_pkg::FN_ADDU, isa_pkg::FN_SUBU, isa_pkg::FN_AND, isa_pkg::FN_OR,
            isa_pkg::FN_XOR, isa_pkg::FN_SLT, isa_pkg::FN_SLL, isa_pkg::FN_SRL};
    foreach (ops[i]) begin
      a = next_operand();
      b = next_operand();
      sh = a[4:0];
      load_const(5'd8, a);
      load_const(5'd9, b);
      if (ops[i] == isa_pkg::FN_SLL || ops[i] == isa_pkg::FN_SRL) begin
        prog.push_back(r_format(5'd0, 5'd9, 5'd2, sh, ops[i]));
      end else begin
        prog.push_back(r_format(5'd8, 5'd9, 5'd2, 5'd0, ops[i]));
      end
      append_halt();
      run_program(ref_result(isa_pkg::OP_SPECIAL, ops[i], a, b, sh, 16'h0000), 1'b0, 32'd0);
    end
  endtask

  task automatic immediate_programs();
    isa_pkg::word_t a;
    isa_pkg::word_t tmp;
    isa_pkg::imm_t  imm;
    a = next_operand();
    tmp = next_operand();
    // Sign bit forced so ADDIU subtracts
    imm = tmp[15:0] | 16'h8000;
    load_const(5'd8, a);
    prog.push_back(i_format(isa_pkg::OP_ADDIU, 5'd8, 5'd2, imm));
    append_halt();
    run_program(ref_result(isa_pkg::OP_ADDIU, isa_pkg::FN_SLL, a, 32'd0, 5'd0, imm),
                1'b0, 32'd0);
    a = next_operand();
    tmp = next_operand();
    imm = tmp[15:0];
    load_const(5'd8, a);
    prog.push_back(i_format(isa_pkg::OP_ORI, 5'd8, 5'd2, imm));
    append_halt();
    run_program(ref_result(isa_pkg::OP_ORI, isa_pkg::FN_SLL, a, 32'd0, 5'd0, imm),
                1'b0, 32'd0);
    tmp = next_operand();
    imm = tmp[31:16];
    prog.push_back(i_format(isa_pkg::OP_LUI, 5'd0, 5'd2, imm));
    append_halt();
    run_program(ref_result(isa_pkg::OP_LUI, isa_pkg::FN_SLL, 32'd0, 32'd0, 5'd0, imm),
                1'b0, 32'd0);
  endtask

  task automatic load_store_program();
    isa_pkg::word_t v;
    v = next_operand();
    load_const(5'd8, v);
    prog.push_back(i_format(isa_pkg::OP_ORI, 5'd0, 5'd10, 16'h1000));
    prog.push_back(i_format(isa_pkg::OP_SW, 5'd10, 5'd8, 16'h0000));
    prog.push_back(i_format(isa_pkg::OP_LW, 5'd10, 5'd2, 16'h0000));
    append_halt();
    run_program(v, 1'b1, v);
  endtask

  // Delay slot adds 0x1, skipped slot adds 0x10, target adds 0x100
  task automatic branch_program(input isa_pkg::opcode_t op, input logic equal);
    logic taken;
    taken = (op == isa_pkg::OP_BEQ) ? equal : !equal;
    prog.push_back(i_format(isa_pkg::OP_ORI, 5'd0, 5'd8, 16'd5));
    prog.push_back(i_format(isa_pkg::OP_ORI, 5'd0, 5'd9, equal ? 16'd5 : 16'd6));
    prog.push_back(i_format(isa_pkg::OP_ORI, 5'd0, 5'd2, 16'd0));
    prog.push_back(i_format(op, 5'd8, 5'd9, 16'd2));
    prog.push_back(i_format(isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0001));
    prog.push_back(i_format(isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0010));
    prog.push_back(i_format(isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0100));
    append_halt();
    run_program(taken ? 32'h0000_0101 : 32'h0000_0111, 1'b0, 32'd0);
  endtask

  task automatic jal_program();
    isa_pkg::word_t target;
    target = `CPU_RESET_VECTOR + 32'd16;
    prog.push_back(j_format(isa_pkg::OP_JAL, target[27:2]));
    prog.push_back(i_format(isa_pkg::OP_ORI, 5'd0, 5'd2, 16'h0055));
    prog.push_back(i_format(isa_pkg::OP_ORI, 5'd0, 5'd2, 16'h0077));
    prog.push_back(32'h0000_0000);
    prog.push_back(r_format(5'd31, 5'd0, 5'd2, 5'd0, isa_pkg::FN_ADDU));
    append_halt();
    run_program(`CPU_RESET_VECTOR + 32'd8, 1'b0, 32'd0);
  endtask

  initial begin
    rst_i = 1'b1;
    waitrequest_i = 1'b0;
    readdata_i = 32'd0;
    random_wait = 1'b0;
    for (int pass = 0; pass < 2; pass++) begin
      random_wait = (pass == 1);
      rtype_programs();
      immediate_programs();
      load_store_program();
      branch_program(isa_pkg::OP_BEQ, 1'b1);
      branch_program(isa_pkg::OP_BEQ, 1'b0);
      branch_program(isa_pkg::OP_BNE, 1'b0);
      branch_program(isa_pkg::OP_BNE, 1'b1);
      jal_program();
    end
    if (u_dut.u_sva.fail_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      stop_with_failure("A bus protocol or halt assertion failed");
    end
  end

endmodule
